/* hw/bit_population_counter.sv */
`default_nettype none

// Tree of adders, one register per level. Widths that are not a power of
// two are padded with zeros up to the next power of two, so both halves
// always have the same depth and their valids line up.
module bit_population_counter #(
  parameter int WIDTH = 32
)(
  input  wire                       clk_i,
  input  wire                       srst_i,
  input  wire  [WIDTH-1:0]          data_i,
  input  wire                       data_val_i,

  output logic [$clog2(WIDTH):0]    data_o,
  output logic                      data_val_o
);

  generate
    if (WIDTH == 1)
      begin : g_leaf
        // ------------------------------------------------
        // Single bit, its count is the bit itself
        // ------------------------------------------------
        always_ff @(posedge clk_i)
          begin
            if (srst_i)
              begin
                data_o     <= '0;
                data_val_o <= 1'b0;
              end
            else
              begin
                data_val_o <= data_val_i;
                data_o     <= data_val_i ? data_i : 1'b0;  // Zero when idle
              end
          end
      end
    else
      begin : g_node
        // Half of the padded width
        localparam int HALF_W = (1 << $clog2(WIDTH)) / 2;

        logic [2*HALF_W-1:0]     data_pad;
        logic [$clog2(HALF_W):0] cnt_lo;
        logic [$clog2(HALF_W):0] cnt_hi;
        logic                    val_lo;
        logic                    val_hi;

        always_comb
          begin
            data_pad              = '0;
            data_pad[WIDTH-1:0]   = data_i;  // Upper bits stay zero
          end

        bit_population_counter #(
          .WIDTH      ( HALF_W                   )
        ) u_lo (
          .clk_i      ( clk_i                    ),
          .srst_i     ( srst_i                   ),
          .data_i     ( data_pad[HALF_W-1:0]     ),
          .data_val_i ( data_val_i               ),
          .data_o     ( cnt_lo                   ),
          .data_val_o ( val_lo                   )
        );

        bit_population_counter #(
          .WIDTH      ( HALF_W                   )
        ) u_hi (
          .clk_i      ( clk_i                    ),
          .srst_i     ( srst_i                   ),
          .data_i     ( data_pad[2*HALF_W-1:HALF_W] ),
          .data_val_i ( data_val_i               ),
          .data_o     ( cnt_hi                   ),
          .data_val_o ( val_hi                   )
        );

        // ------------------------------------------------
        // Add the two halves
        // ------------------------------------------------
        always_ff @(posedge clk_i)
          begin
            if (srst_i)
              begin
                data_o     <= '0;
                data_val_o <= 1'b0;
              end
            else
              begin
                data_val_o <= val_lo && val_hi;
                if (val_lo && val_hi)
                  data_o <= {1'b0, cnt_lo} + {1'b0, cnt_hi};  // One bit wider than a half
                else
                  data_o <= '0;
              end
          end
      end
  endgenerate

endmodule

`default_nettype wire

/* hw/frame_ctrl_fsm.sv */
`default_nettype none

module frame_ctrl_fsm (
  input  wire  clk_i,
  input  wire  srst_i,
  input  wire  start_i,
  input  wire  data_val_i,
  input  wire  last_in_i,
  input  wire  last_out_i,

  output logic word_acc_o,
  output logic clear_o,
  output logic frame_done_o
);

  popcount_pkg::frame_state_e state_q;
  popcount_pkg::frame_state_e state_d;

  // ------------------------------------------------
  // Next state
  // ------------------------------------------------
  always_comb
    begin
      state_d = state_q;
      case (state_q)
        popcount_pkg::IDLE:
          begin
            if (start_i)
              state_d = popcount_pkg::COLLECT;
          end
        popcount_pkg::COLLECT:
          begin
            if (last_in_i)
              state_d = popcount_pkg::DRAIN;     // Eighth word taken
          end
        popcount_pkg::DRAIN:
          begin
            if (last_out_i)
              state_d = popcount_pkg::DONE;      // Eighth result out
          end
        popcount_pkg::DONE:
          begin
            state_d = popcount_pkg::IDLE;        // Summary shown for one cycle
          end
        default:
          begin
            state_d = popcount_pkg::IDLE;
          end
      endcase
    end

  always_ff @(posedge clk_i)
    begin
      if (srst_i)
        state_q <= popcount_pkg::IDLE;
      else
        state_q <= state_d;
    end

  // ------------------------------------------------
  // Outputs
  // ------------------------------------------------
  // Words outside COLLECT never reach the pipeline
  assign word_acc_o   = data_val_i && (state_q == popcount_pkg::COLLECT);
  assign clear_o      = start_i    && (state_q == popcount_pkg::IDLE);  // Only the accepted start
  assign frame_done_o = (state_q == popcount_pkg::DONE);

endmodule

`default_nettype wire

/* hw/frame_word_counter.sv */
`default_nettype none

module frame_word_counter (
  input  wire  clk_i,
  input  wire  srst_i,
  input  wire  clear_i,
  input  wire  word_acc_i,
  input  wire  result_val_i,

  output logic last_in_o,
  output logic last_out_o
);

  logic [popcount_pkg::IDX_W-1:0] in_cnt;     // Words accepted so far
  logic [popcount_pkg::IDX_W-1:0] out_cnt;    // Results returned so far

  // ------------------------------------------------
  // Input and output side counters
  // ------------------------------------------------
  always_ff @(posedge clk_i)
    begin
      if (srst_i || clear_i)
        in_cnt <= '0;
      else if (word_acc_i)
        in_cnt <= in_cnt + 1'b1;
    end

  always_ff @(posedge clk_i)
    begin
      if (srst_i || clear_i)
        out_cnt <= '0;
      else if (result_val_i)
        out_cnt <= out_cnt + 1'b1;
    end

  // Flags mark the strobe that completes the frame
  assign last_in_o  = word_acc_i &&
                      (in_cnt == (popcount_pkg::IDX_W)'(popcount_pkg::FRAME_WORDS - 1));
  assign last_out_o = result_val_i &&
                      (out_cnt == (popcount_pkg::IDX_W)'(popcount_pkg::FRAME_WORDS - 1));

endmodule

`default_nettype wire

/* hw/popcount_accumulator.sv */
`default_nettype none

module popcount_accumulator (
  input  wire                           clk_i,
  input  wire                           srst_i,
  input  wire                           clear_i,
  input  wire popcount_pkg::pop_result_t result_i,

  output popcount_pkg::frame_summary_t  summary_o
);

  logic [popcount_pkg::SUM_W-1:0] count_ext;
  logic [popcount_pkg::SUM_W-1:0] total_nxt;
  logic [popcount_pkg::POP_W-1:0] max_nxt;

  // ------------------------------------------------
  // Running total and maximum
  // ------------------------------------------------
  assign count_ext = {{(popcount_pkg::SUM_W - popcount_pkg::POP_W){1'b0}}, result_i.count};
  assign total_nxt = summary_o.total + count_ext;

  always_comb
    begin
      if (result_i.count > summary_o.max)
        max_nxt = result_i.count;  // New largest word
      else
        max_nxt = summary_o.max;
    end

  always_ff @(posedge clk_i)
    begin
      if (srst_i)
        begin
          summary_o <= '0;
        end
      else if (clear_i)
        begin
          summary_o <= '0;         // Fresh frame
        end
      else if (result_i.valid)
        begin
          summary_o.total <= total_nxt;
          summary_o.max   <= max_nxt;
        end
    end

endmodule

`default_nettype wire

/* hw/popcount_frame_top.sv */
`default_nettype none

module popcount_frame_top (
  input  wire                                clk_i,
  input  wire                                srst_i,
  input  wire                                start_i,
  input  wire  [popcount_pkg::DATA_W-1:0]    data_i,
  input  wire                                data_val_i,

  output logic [popcount_pkg::POP_W-1:0]     pop_o,
  output logic                               pop_val_o,
  output popcount_pkg::frame_summary_t       summary_o,
  output logic                               frame_done_o
);

  logic                      word_acc;     // Qualified input strobe
  logic                      frame_clear;
  logic                      last_in;
  logic                      last_out;
  popcount_pkg::pop_result_t pop_res;

  // ------------------------------------------------
  // Control
  // ------------------------------------------------
  frame_ctrl_fsm u_fsm (
    .clk_i        ( clk_i        ),
    .srst_i       ( srst_i       ),
    .start_i      ( start_i      ),
    .data_val_i   ( data_val_i   ),
    .last_in_i    ( last_in      ),
    .last_out_i   ( last_out     ),
    .word_acc_o   ( word_acc     ),
    .clear_o      ( frame_clear  ),
    .frame_done_o ( frame_done_o )
  );

  frame_word_counter u_cnt (
    .clk_i        ( clk_i        ),
    .srst_i       ( srst_i       ),
    .clear_i      ( frame_clear  ),
    .word_acc_i   ( word_acc     ),
    .result_val_i ( pop_res.valid ),
    .last_in_o    ( last_in      ),
    .last_out_o   ( last_out     )
  );

  // ------------------------------------------------
  // Datapath
  // ------------------------------------------------
  bit_population_counter #(
    .WIDTH        ( popcount_pkg::DATA_W )
  ) u_pop (
    .clk_i        ( clk_i        ),
    .srst_i       ( srst_i       ),
    .data_i       ( data_i       ),
    .data_val_i   ( word_acc     ),
    .data_o       ( pop_o        ),
    .data_val_o   ( pop_val_o    )
  );

  assign pop_res = '{count: pop_o, valid: pop_val_o};

  popcount_accumulator u_acc (
    .clk_i        ( clk_i        ),
    .srst_i       ( srst_i       ),
    .clear_i      ( frame_clear  ),
    .result_i     ( pop_res      ),
    .summary_o    ( summary_o    )
  );

endmodule

`default_nettype wire

/* hw/popcount_pkg.sv */
`default_nettype none

package popcount_pkg;

  // ------------------------------------------------
  // Word and frame geometry
  // ------------------------------------------------
  localparam int DATA_W      = 32;                                // Input word width
  localparam int POP_W       = $clog2(DATA_W) + 1;                // Holds 0 .. DATA_W
  localparam int FRAME_WORDS = 8;                                 // Words per frame
  localparam int IDX_W       = $clog2(FRAME_WORDS);               // Word / result index
  localparam int SUM_W       = $clog2(FRAME_WORDS * DATA_W) + 1;  // Frame total
  localparam int POP_LATENCY = $clog2(DATA_W) + 1;                // Leaf stage plus one per level

  // ------------------------------------------------
  // Frame control and result types
  // ------------------------------------------------
  typedef enum logic [1:0] {
    IDLE,
    COLLECT,
    DRAIN,
    DONE
  } frame_state_e;

  typedef struct packed {
    logic [POP_W-1:0] count;  // Ones in one word
    logic             valid;
  } pop_result_t;

  typedef struct packed {
    logic [SUM_W-1:0] total;  // Sum over the frame
    logic [POP_W-1:0] max;    // Largest single count
  } frame_summary_t;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build the popcount frame testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module popcount_frame_tb \
  -Mdir obj_dir -o popcount_frame_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit "$build_status"
fi

./obj_dir/popcount_frame_sim
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
  echo "Simulation ended with status $sim_status"
  exit "$sim_status"
fi

exit 0

/* sim/popcount_frame_patterns.txt */
// Column 1: 32-bit input word (hex)
// Column 2: its expected ones count (hex); lines 1-8 frame 0, lines 9-16 frame 1
00000001 01
000000ff 08
80000001 02
0f0f0f0f 10
12345678 0d
7ffffffe 1e
a5a5a5a5 10
00000003 02
ffffffff 20
00000000 00
deadbeef 18
00000010 01
55555555 10
f000000f 08
01010101 04
00ffff00 10

/* sim/popcount_frame_props.sv */
`default_nettype none

module popcount_frame_props (
  input wire                             clk_i,
  input wire                             srst_i,
  input wire popcount_pkg::frame_state_e state_i,
  input wire                             word_acc_i,
  input wire                             frame_done_i
);

  int unsigned drain_len;  // Cycles already spent in DRAIN

  always_ff @(posedge clk_i)
    begin
      if (srst_i || (state_i != popcount_pkg::DRAIN))
        drain_len <= 0;
      else
        drain_len <= drain_len + 1;
    end

  a_done_pulse: assert property (@(posedge clk_i) disable iff (srst_i)
    frame_done_i |=> !frame_done_i)
    else $error("frame_done_o high for more than one cycle");

  a_accept_collect: assert property (@(posedge clk_i) disable iff (srst_i)
    word_acc_i |-> (state_i == popcount_pkg::COLLECT))
    else $error("word accepted outside COLLECT");

  // Index of the current DRAIN cycle, so the bound is one extra cycle
  a_drain_bound: assert property (@(posedge clk_i) disable iff (srst_i)
    (state_i == popcount_pkg::DRAIN) |-> (drain_len <= popcount_pkg::POP_LATENCY))
    else $error("DRAIN lasted longer than the pipeline latency plus one");

endmodule

bind frame_ctrl_fsm popcount_frame_props u_props (
  .clk_i        ( clk_i        ),
  .srst_i       ( srst_i       ),
  .state_i      ( state_q      ),
  .word_acc_i   ( word_acc_o   ),
  .frame_done_i ( frame_done_o )
);

`default_nettype wire

/* sim/popcount_frame_tb.sv */
`default_nettype none

module popcount_frame_tb;

  localparam int NUM_WORDS = 16;
  localparam int TIMEOUT   = 2 * 16 * (4 + popcount_pkg::POP_LATENCY) + 200;

  typedef struct packed {
    logic [31:0]                    due;    // Cycle in which the count must show
    logic [popcount_pkg::POP_W-1:0] count;
  } exp_entry_t;

  logic                            clk_i;
  logic                            srst_i;
  logic                            start_i;
  logic [popcount_pkg::DATA_W-1:0] data_i;
  logic                            data_val_i;
  logic [popcount_pkg::POP_W-1:0]  pop_o;
  logic                            pop_val_o;
  popcount_pkg::frame_summary_t    summary_o;
  logic                            frame_done_o;

  logic [31:0]                     pat_mem [0:2*NUM_WORDS-1];  // Word, count, word, count
  logic [31:0]                     lfsr = 32'h6b28;
  int unsigned                     cycle_cnt;
  int unsigned                     results_seen;
  int unsigned                     done_seen;
  int unsigned                     done_due;
  popcount_pkg::frame_summary_t    exp_sum;   // Built from the pattern counts
  exp_entry_t                      exp_q[$];
  exp_entry_t                      head;

  popcount_frame_top u_popcount_frame_top (.*);

  // --------------------------------------------------
  // Failure handling
  // --------------------------------------------------
  task automatic halt_failed();
    $display("Test FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic flag_mismatch(input string name, input logic [31:0] expv,
                               input logic [31:0] actv);
    $display("FAILED %s expected %0d actual %0d", name, expv, actv);
    halt_failed();
  endtask

  task automatic abort_run(input string msg);
    $display("ERROR %s", msg);
    halt_failed();
  endtask

  // 32-bit Fibonacci LFSR with taps 32 22 2 1
  function automatic int unsigned lfsr_bits(input int n);
    int unsigned val;
    val = 0;
    repeat (n)
      begin
        lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        val  = {val[30:0], lfsr[0]};
      end
    return val;
  endfunction

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  task automatic end_reset();
    repeat (5) @(posedge clk_i);
    srst_i <= 1'b0;
  endtask

  task automatic drive(input logic start, input logic val, input logic [31:0] word);
    @(posedge clk_i);
    start_i    <= start;
    data_val_i <= val;
    data_i     <= word;
  endtask

  task automatic run_frame(input int frame, input bit gaps);
    int                             i;
    int                             idx;
    int unsigned                    gap;
    logic                           first;
    logic [popcount_pkg::POP_W-1:0] cnt;
    exp_sum = '0;
    drive(1'b1, 1'b0, '0);  // Open the frame
    for (i = 0; i < popcount_pkg::FRAME_WORDS; i++)
      begin
        if (gaps)
          begin
            gap = lfsr_bits(2);
            repeat (gap) drive(1'b0, 1'b0, '0);
          end
        idx = 2 * (frame * popcount_pkg::FRAME_WORDS + i);
        cnt = pat_mem[idx + 1][popcount_pkg::POP_W-1:0];
        drive(i == 3, 1'b1, pat_mem[idx]);  // Start in mid frame must be ignored
        exp_q.push_back('{due: cycle_cnt + 1 + popcount_pkg::POP_LATENCY, count: cnt});
        exp_sum.total = exp_sum.total + (popcount_pkg::SUM_W)'(cnt);
        if (cnt > exp_sum.max)
          exp_sum.max = cnt;
      end
    first = 1'b1;
    do
      begin
        drive(first, 1'b1, 32'hFFFF_FFFF);  // Dropped in DRAIN, DONE and IDLE
        first = 1'b0;
      end
    while (!frame_done_o);
    drive(1'b0, 1'b0, '0);
  endtask

  // --------------------------------------------------
  // Output checks on the falling edge
  // --------------------------------------------------
  always @(negedge clk_i)
    begin
      if (!srst_i && pop_val_o)
        begin
          assert (exp_q.size() > 0) else abort_run("result without an accepted word");
          head = exp_q.pop_front();
          assert (cycle_cnt == head.due) else flag_mismatch("pop cycle", head.due, cycle_cnt);
          assert (pop_o == head.count)
            else flag_mismatch("pop count", 32'(head.count), 32'(pop_o));
          results_seen++;
          if (results_seen % popcount_pkg::FRAME_WORDS == 0)
            done_due = cycle_cnt + 1;  // Summary follows the eighth result
        end
      if (!srst_i && frame_done_o)
        begin
          assert (cycle_cnt == done_due) else flag_mismatch("done cycle", done_due, cycle_cnt);
          assert (summary_o.total == exp_sum.total)
            else flag_mismatch("frame total", 32'(exp_sum.total), 32'(summary_o.total));
          assert (summary_o.max == exp_sum.max)
            else flag_mismatch("frame max", 32'(exp_sum.max), 32'(summary_o.max));
          done_seen++;
        end
      else if (!srst_i)
        begin
          assert (cycle_cnt != done_due) else abort_run("frame_done_o missing");
        end
    end

  always @(posedge clk_i)
    begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt > TIMEOUT)
        abort_run("timeout, the run did not finish within the cycle limit");
    end

  initial
    begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
    end

  initial
    begin
      srst_i     = 1'b1;
      start_i    = 1'b0;
      data_i     = '0;
      data_val_i = 1'b0;
      $readmemh("sim/popcount_frame_patterns.txt", pat_mem);
      end_reset();
      repeat (3)
        begin
          drive(1'b0, 1'b1, 32'h0F0F_0F0F);  // No frame open yet
          drive(1'b0, 1'b0, '0);
        end
      repeat (popcount_pkg::POP_LATENCY + 2) drive(1'b0, 1'b0, '0);
      run_frame(0, 1'b0);  // Back to back words
      run_frame(1, 1'b1);
      run_frame(0, 1'b1);
      repeat (2) drive(1'b0, 1'b0, '0);
      assert (done_seen == 3) else flag_mismatch("frame count", 3, done_seen);
      assert (exp_q.size() == 0) else abort_run("accepted words without a result");
      $display("Test OK");
      $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
hw/popcount_pkg.sv
hw/bit_population_counter.sv
hw/frame_word_counter.sv
hw/frame_ctrl_fsm.sv
hw/popcount_accumulator.sv
hw/popcount_frame_top.sv
sim/popcount_frame_props.sv
sim/popcount_frame_tb.sv
